/* logic/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // load width and extension as decoded upstream
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5
    } load_op_e;

    // instruction classes handled by the pipeline tail
    typedef enum logic [2:0] {
        KIND_ALU     = 3'd0,
        KIND_LOAD    = 3'd1,
        KIND_CSRRD   = 3'd2,
        KIND_CSRWR   = 3'd3,
        KIND_CSRXCHG = 3'd4,
        KIND_SYSCALL = 3'd5,
        KIND_ERTN    = 3'd6
    } inst_kind_e;

    // record from execute; result doubles as load address
    typedef struct packed {
        logic [31:0] pc;
        inst_kind_e  kind;
        load_op_e    load_op;
        logic [4:0]  rd;
        logic [31:0] result;
        logic [13:0] csr_num;
        logic [31:0] csr_wvalue;
        logic [31:0] csr_wmask;
    } ex2ms_t;

    // record from memory to writeback
    typedef struct packed {
        logic [31:0] pc;
        inst_kind_e  kind;
        logic [4:0]  rd;
        logic        rf_we;
        logic [31:0] wdata;
        logic [13:0] csr_num;
        logic [31:0] csr_wvalue;
        logic [31:0] csr_wmask;
    } ms2ws_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic        re;
        logic        we;
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_req_t;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    // exception codes
    localparam logic [5:0] ECODE_SYS     = 6'hb;
    localparam logic [8:0] ESUBCODE_NONE = 9'h0;

endpackage

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           ex2ms_valid,
    input  wire wb_pkg::ex2ms_t ex2ms,
    input  wire logic [31:0]    load_rdata,
    input  wire logic           ws_allowin,
    input  wire logic           flush,
    output logic                ms_allowin,
    output logic                ms2ws_valid,
    output wb_pkg::ms2ws_t      ms2ws
);

    logic           ms_valid;
    logic           ms_ready_go;
    logic [1:0]     addr_lo;
    logic [31:0]    byte_shift;
    logic [7:0]     ld_byte;
    logic [15:0]    ld_half;
    logic [31:0]    ld_data;
    wb_pkg::ms2ws_t ms_next;

    // single cycle stage, data memory word arrives with the record
    assign ms_ready_go = 1'b1;
    assign ms_allowin  = ~ms_valid | (ms_ready_go & ws_allowin);
    assign ms2ws_valid = ms_valid & ms_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ex2ms_valid;
        end
    end

    // byte lane from the low address bits
    assign addr_lo    = ex2ms.result[1:0];
    assign byte_shift = load_rdata >> {addr_lo, 3'b000};
    assign ld_byte    = byte_shift[7:0];
    // half lane only by bit 1, halves are aligned
    assign ld_half    = addr_lo[1] ? load_rdata[31:16] : load_rdata[15:0];

    always_comb begin
        case (ex2ms.load_op)
            wb_pkg::LD_B:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            wb_pkg::LD_BU: ld_data = {24'b0, ld_byte};
            wb_pkg::LD_H:  ld_data = {{16{ld_half[15]}}, ld_half};
            wb_pkg::LD_HU: ld_data = {16'b0, ld_half};
            wb_pkg::LD_W:  ld_data = load_rdata;
            default:       ld_data = ex2ms.result;
        endcase
    end

    // next record toward writeback
    always_comb begin
        ms_next.pc         = ex2ms.pc;
        ms_next.kind       = ex2ms.kind;
        ms_next.rd         = ex2ms.rd;
        ms_next.csr_num    = ex2ms.csr_num;
        ms_next.csr_wvalue = ex2ms.csr_wvalue;
        ms_next.csr_wmask  = ex2ms.csr_wmask;
        ms_next.wdata      = (ex2ms.kind == wb_pkg::KIND_LOAD) ? ld_data : ex2ms.result;
        // syscall and ertn write nothing, r0 is never written
        case (ex2ms.kind)
            wb_pkg::KIND_ALU,
            wb_pkg::KIND_LOAD,
            wb_pkg::KIND_CSRRD,
            wb_pkg::KIND_CSRWR,
            wb_pkg::KIND_CSRXCHG: ms_next.rf_we = (ex2ms.rd != 5'd0);
            default:              ms_next.rf_we = 1'b0;
        endcase
    end

    // payload register, loaded on each transfer
    always_ff @(posedge clk) begin
        if (ex2ms_valid && ms_allowin) begin
            ms2ws <= ms_next;
        end
    end

endmodule

`default_nettype wire

/* logic/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           ms2ws_valid,
    input  wire wb_pkg::ms2ws_t ms2ws,
    input  wire logic [31:0]    csr_rvalue,
    output logic                ws_allowin,
    output wb_pkg::csr_req_t    csr_req,
    output logic                wb_ex,
    output logic                ertn_flush,
    output logic [31:0]         wb_pc,
    output wb_pkg::rf_write_t   rf_write,
    output logic [31:0]         debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output logic [4:0]          debug_wb_rf_wnum,
    output logic [31:0]         debug_wb_rf_wdata
);

    logic           ws_valid;
    logic           ws_ready_go;
    logic           is_csr;
    logic           is_csr_write;
    wb_pkg::ms2ws_t ws_r;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = ~ws_valid | ws_ready_go;

    // own exception or return drops the stage
    always_ff @(posedge clk) begin
        if (!resetn || wb_ex || ertn_flush) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid && ws_allowin) begin
            ws_r <= ms2ws;
        end
    end

    assign is_csr       = (ws_r.kind == wb_pkg::KIND_CSRRD) ||
                          (ws_r.kind == wb_pkg::KIND_CSRWR) ||
                          (ws_r.kind == wb_pkg::KIND_CSRXCHG);
    assign is_csr_write = (ws_r.kind == wb_pkg::KIND_CSRWR) ||
                          (ws_r.kind == wb_pkg::KIND_CSRXCHG);

    // csr request, only from a valid record
    assign csr_req.re     = ws_valid & is_csr;
    assign csr_req.we     = ws_valid & is_csr_write;
    assign csr_req.num    = ws_r.csr_num;
    // csrwr replaces the whole register, csrxchg uses its mask
    assign csr_req.wmask  = (ws_r.kind == wb_pkg::KIND_CSRWR) ? 32'hffff_ffff : ws_r.csr_wmask;
    assign csr_req.wvalue = ws_r.csr_wvalue;

    assign wb_ex      = ws_valid & (ws_r.kind == wb_pkg::KIND_SYSCALL);
    assign ertn_flush = ws_valid & (ws_r.kind == wb_pkg::KIND_ERTN);
    assign wb_pc      = ws_r.pc;

    // csr kinds return the old csr value to rd
    assign rf_write.we    = ws_valid & ws_r.rf_we;
    assign rf_write.waddr = ws_r.rd;
    assign rf_write.wdata = is_csr ? csr_rvalue : ws_r.wdata;

    // trace follows the qualified write
    assign debug_wb_pc       = ws_r.pc;
    assign debug_wb_rf_we    = {4{rf_write.we}};
    assign debug_wb_rf_wnum  = rf_write.waddr;
    assign debug_wb_rf_wdata = rf_write.wdata;

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [31:0] eentry_reset = 32'h1c00_8000
) (
    input  wire logic             clk,
    input  wire logic             resetn,
    input  wire wb_pkg::csr_req_t csr_req,
    input  wire logic             wb_ex,
    input  wire logic             ertn_flush,
    input  wire logic [31:0]      wb_pc,
    output logic [31:0]           csr_rvalue,
    output logic [31:0]           eentry,
    output logic [31:0]           era
);

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:6] eentry_va;
    logic [31:0] save_r [4];
    logic [31:0] merged;
    logic        save_hit;

    // combinational read by number, unknown reads zero
    always_comb begin
        case (csr_req.num)
            wb_pkg::CSR_CRMD:   csr_rvalue = {29'b0, crmd_ie, crmd_plv};
            wb_pkg::CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            wb_pkg::CSR_ESTAT:  csr_rvalue = {1'b0, estat_esubcode, estat_ecode, 16'b0};
            wb_pkg::CSR_ERA:    csr_rvalue = era;
            wb_pkg::CSR_EENTRY: csr_rvalue = eentry;
            wb_pkg::CSR_SAVE0:  csr_rvalue = save_r[0];
            wb_pkg::CSR_SAVE1:  csr_rvalue = save_r[1];
            wb_pkg::CSR_SAVE2:  csr_rvalue = save_r[2];
            wb_pkg::CSR_SAVE3:  csr_rvalue = save_r[3];
            default:            csr_rvalue = 32'b0;
        endcase
    end

    // read value is the old content of the addressed register
    assign merged   = (csr_rvalue & ~csr_req.wmask) | (csr_req.wvalue & csr_req.wmask);
    assign save_hit = (csr_req.num >= wb_pkg::CSR_SAVE0) && (csr_req.num <= wb_pkg::CSR_SAVE3);

    // crmd and prmd: exception entry, return, software write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            // save then drop to kernel with interrupts off
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_req.we && csr_req.num == wb_pkg::CSR_CRMD) begin
            crmd_plv <= merged[1:0];
            crmd_ie  <= merged[2];
        end else if (csr_req.we && csr_req.num == wb_pkg::CSR_PRMD) begin
            prmd_pplv <= merged[1:0];
            prmd_pie  <= merged[2];
        end
    end

    // estat is read only to software
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_pkg::ECODE_SYS;
            estat_esubcode <= wb_pkg::ESUBCODE_NONE;
        end
    end

    // era takes the pc of the trapping instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= 32'b0;
        end else if (wb_ex) begin
            era <= wb_pc;
        end else if (csr_req.we && csr_req.num == wb_pkg::CSR_ERA) begin
            era <= merged;
        end
    end

    // entry kept 64 byte aligned
    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= eentry_reset[31:6];
        end else if (csr_req.we && csr_req.num == wb_pkg::CSR_EENTRY) begin
            eentry_va <= merged[31:6];
        end
    end

    assign eentry = {eentry_va, 6'b0};

    // scratch registers, low number bits pick the slot
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                save_r[i] <= 32'b0;
            end
        end else if (csr_req.we && save_hit) begin
            save_r[csr_req.num[1:0]] <= merged;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire wb_pkg::rf_write_t rf_write,
    input  wire logic [4:0]        raddr,
    output logic [31:0]            rdata
);

    // storage only, contents undefined until written
    logic [31:0] regs [32];

    // write at the edge ending the writeback cycle
    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.waddr != 5'd0) begin
            regs[rf_write.waddr] <= rf_write.wdata;
        end
    end

    // asynchronous read, r0 hardwired to zero
    assign rdata = (raddr == 5'd0) ? 32'b0 : regs[raddr];

endmodule

`default_nettype wire

/* logic/wb_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_core_top #(
    parameter logic [31:0] eentry_reset = 32'h1c00_8000
) (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           ex2ms_valid,
    input  wire wb_pkg::ex2ms_t ex2ms,
    input  wire logic [31:0]    load_rdata,
    input  wire logic [4:0]     rf_raddr,
    output logic                ms_allowin,
    output logic [31:0]         rf_rdata,
    output logic                flush,
    output logic [31:0]         flush_pc,
    output logic [31:0]         debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output logic [4:0]          debug_wb_rf_wnum,
    output logic [31:0]         debug_wb_rf_wdata
);

    logic              ms2ws_valid;
    logic              ws_allowin;
    wb_pkg::ms2ws_t    ms2ws;
    wb_pkg::csr_req_t  csr_req;
    wb_pkg::rf_write_t rf_write;
    logic              wb_ex;
    logic              ertn_flush;
    logic [31:0]       wb_pc;
    logic [31:0]       csr_rvalue;
    logic [31:0]       eentry;
    logic [31:0]       era;

    // syscall goes to the entry, ertn back to era
    assign flush    = wb_ex | ertn_flush;
    assign flush_pc = wb_ex ? eentry : era;

    mem_stage u_mem_stage (
        .clk         (clk),
        .resetn      (resetn),
        .ex2ms_valid (ex2ms_valid),
        .ex2ms       (ex2ms),
        .load_rdata  (load_rdata),
        .ws_allowin  (ws_allowin),
        .flush       (flush),
        .ms_allowin  (ms_allowin),
        .ms2ws_valid (ms2ws_valid),
        .ms2ws       (ms2ws)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ms2ws_valid       (ms2ws_valid),
        .ms2ws             (ms2ws),
        .csr_rvalue        (csr_rvalue),
        .ws_allowin        (ws_allowin),
        .csr_req           (csr_req),
        .wb_ex             (wb_ex),
        .ertn_flush        (ertn_flush),
        .wb_pc             (wb_pc),
        .rf_write          (rf_write),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(
        .eentry_reset (eentry_reset)
    ) u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .wb_ex      (wb_ex),
        .ertn_flush (ertn_flush),
        .wb_pc      (wb_pc),
        .csr_rvalue (csr_rvalue),
        .eentry     (eentry),
        .era        (era)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rf_write (rf_write),
        .raddr    (rf_raddr),
        .rdata    (rf_rdata)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

/* verif/wb_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_asserts (
    input wire logic       clk,
    input wire logic       resetn,
    input wire logic       ws_valid,
    input wire logic       wb_ex,
    input wire logic       ertn_flush,
    input wire logic [3:0] debug_wb_rf_we
);

    // syscall and ertn are separate kinds
    ex_ertn_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(wb_ex && ertn_flush))
        else $error("wb_ex and ertn_flush high in the same cycle");

    // trace only from a live record
    trace_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        (|debug_wb_rf_we) |-> ws_valid)
        else $error("trace write enable without a valid writeback record");

    // stage is empty right after its own flush
    no_trace_after_flush: assert property (@(posedge clk) disable iff (!resetn)
        (wb_ex || ertn_flush) |=> (debug_wb_rf_we == 4'b0))
        else $error("trace write in the cycle after a flush");

endmodule

bind wb_stage wb_asserts u_wb_asserts (
    .clk            (clk),
    .resetn         (resetn),
    .ws_valid       (ws_valid),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .debug_wb_rf_we (debug_wb_rf_we)
);

`default_nettype wire

/* verif/wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_tb;

    localparam logic [31:0] EENTRY_RESET = 32'h1c00_8000;
    localparam int          WAIT_LIMIT   = 20;

    // flush pair seen by the fetch side
    typedef struct packed {
        logic        flush;
        logic [31:0] pc;
    } flush_t;

    logic              clk;
    logic              resetn;
    logic              ex2ms_valid;
    wb_pkg::ex2ms_t    ex2ms;
    logic [31:0]       load_rdata;
    logic [4:0]        rf_raddr;
    logic              ms_allowin;
    logic [31:0]       rf_rdata;
    logic              flush;
    logic [31:0]       flush_pc;
    logic [31:0]       debug_wb_pc;
    logic [3:0]        debug_wb_rf_we;
    logic [4:0]        debug_wb_rf_wnum;
    logic [31:0]       debug_wb_rf_wdata;

    // reference model of registers and csrs
    logic [31:0] rf_m [32];
    logic [31:0] crmd_m;
    logic [31:0] prmd_m;
    logic [31:0] estat_m;
    logic [31:0] era_m;
    logic [31:0] eentry_m;
    logic [31:0] save_m [4];
    logic [31:0] pc_next;
    int          mismatch_count;
    int          timeout_count;
    int          squash_count;

    tb_clock u_clock (
        .clk (clk)
    );

    wb_core_top #(
        .eentry_reset (EENTRY_RESET)
    ) DUT (
        .clk               (clk),
        .resetn            (resetn),
        .ex2ms_valid       (ex2ms_valid),
        .ex2ms             (ex2ms),
        .load_rdata        (load_rdata),
        .rf_raddr          (rf_raddr),
        .ms_allowin        (ms_allowin),
        .rf_rdata          (rf_rdata),
        .flush             (flush),
        .flush_pc          (flush_pc),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // waddr and wdata only matter when a write is expected
    task automatic compare_rf_write(input wb_pkg::rf_write_t got, input wb_pkg::rf_write_t exp);
        if (got.we !== exp.we ||
            (exp.we && (got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
            mismatch_count++;
            $display({"Error at %0t: debug_wb_rf got we %b wnum %0d wdata %h",
                      " expected we %b wnum %0d wdata %h"},
                     $time, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
        end
    endtask

    task automatic compare_flush(input flush_t got, input flush_t exp);
        if (got.flush !== exp.flush || (exp.flush && got.pc !== exp.pc)) begin
            mismatch_count++;
            $display("Error at %0t: flush/flush_pc got %b/%h expected %b/%h",
                     $time, got.flush, got.pc, exp.flush, exp.pc);
        end
    endtask

    function automatic wb_pkg::rf_write_t trace_now();
        wb_pkg::rf_write_t t;
        t.we    = |debug_wb_rf_we;
        t.waddr = debug_wb_rf_wnum;
        t.wdata = debug_wb_rf_wdata;
        return t;
    endfunction

    function automatic flush_t flush_now();
        flush_t f;
        f.flush = flush;
        f.pc    = flush_pc;
        return f;
    endfunction

    function automatic wb_pkg::rf_write_t expect_write(input logic [4:0] rd,
                                                       input logic [31:0] data);
        wb_pkg::rf_write_t w;
        w.we    = (rd != 5'd0);
        w.waddr = rd;
        w.wdata = data;
        return w;
    endfunction

    // each record gets a fresh pc, the retire wait keys on it
    function automatic wb_pkg::ex2ms_t make_rec(input wb_pkg::inst_kind_e kind,
                                                input logic [4:0] rd, input logic [31:0] result);
        wb_pkg::ex2ms_t rec;
        rec         = '0;
        rec.pc      = pc_next;
        rec.kind    = kind;
        rec.load_op = wb_pkg::LD_NONE;
        rec.rd      = rd;
        rec.result  = result;
        pc_next     = pc_next + 32'd4;
        return rec;
    endfunction

    // byte by offset, half by offset bit 1
    function automatic logic [31:0] extend_load(input wb_pkg::load_op_e op, input logic [1:0] off,
                                                input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            wb_pkg::LD_B:  return {{24{b[7]}}, b};
            wb_pkg::LD_BU: return {24'b0, b};
            wb_pkg::LD_H:  return {{16{h[15]}}, h};
            wb_pkg::LD_HU: return {16'b0, h};
            default:       return word;
        endcase
    endfunction

    function automatic logic [31:0] writable_bits(input logic [13:0] num);
        case (num)
            wb_pkg::CSR_CRMD, wb_pkg::CSR_PRMD: return 32'h0000_0007;
            wb_pkg::CSR_ERA, wb_pkg::CSR_SAVE0, wb_pkg::CSR_SAVE1,
            wb_pkg::CSR_SAVE2, wb_pkg::CSR_SAVE3: return 32'hffff_ffff;
            // entry stays 64 byte aligned
            wb_pkg::CSR_EENTRY: return 32'hffff_ffc0;
            default:            return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] csr_value_of(input logic [13:0] num);
        case (num)
            wb_pkg::CSR_CRMD:   return crmd_m;
            wb_pkg::CSR_PRMD:   return prmd_m;
            wb_pkg::CSR_ESTAT:  return estat_m;
            wb_pkg::CSR_ERA:    return era_m;
            wb_pkg::CSR_EENTRY: return eentry_m;
            wb_pkg::CSR_SAVE0:  return save_m[0];
            wb_pkg::CSR_SAVE1:  return save_m[1];
            wb_pkg::CSR_SAVE2:  return save_m[2];
            wb_pkg::CSR_SAVE3:  return save_m[3];
            default:            return 32'h0;
        endcase
    endfunction

    task automatic store_csr(input logic [13:0] num, input logic [31:0] value);
        case (num)
            wb_pkg::CSR_CRMD:   crmd_m = value;
            wb_pkg::CSR_PRMD:   prmd_m = value;
            wb_pkg::CSR_ERA:    era_m = value;
            wb_pkg::CSR_EENTRY: eentry_m = value;
            wb_pkg::CSR_SAVE0:  save_m[0] = value;
            wb_pkg::CSR_SAVE1:  save_m[1] = value;
            wb_pkg::CSR_SAVE2:  save_m[2] = value;
            wb_pkg::CSR_SAVE3:  save_m[3] = value;
            default:            ;
        endcase
    endtask

    // syscall entry, ecode sits at bits 21:16
    task automatic enter_exception(input logic [31:0] pc);
        prmd_m  = crmd_m & 32'h7;
        crmd_m  = 32'h0;
        era_m   = pc;
        estat_m = 32'h000b_0000;
    endtask

    // called on a rising edge, returns on the edge that accepted the record
    task automatic issue(input wb_pkg::ex2ms_t rec, input logic [31:0] rdata);
        int   cycles;
        logic accepted;
        ex2ms_valid <= 1'b1;
        ex2ms       <= rec;
        load_rdata  <= rdata;
        cycles = 0;
        accepted = 1'b0;
        while (!accepted && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            accepted = ms_allowin;
            @(posedge clk);
            cycles++;
        end
        ex2ms_valid <= 1'b0;
        if (!accepted) begin
            timeout_count++;
            $display("Timeout: memory stage never accepted the record at pc %h", rec.pc);
        end
    endtask

    task automatic wait_retire(input logic [31:0] pc, output logic found);
        int cycles;
        found = 1'b0;
        cycles = 0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            found = (debug_wb_pc === pc);
            cycles++;
        end
        if (!found) begin
            timeout_count++;
            $display("Timeout: instruction at pc %h never reached writeback", pc);
        end
    endtask

    task automatic execute_and_check(input wb_pkg::ex2ms_t rec, input logic [31:0] rdata,
                                     input wb_pkg::rf_write_t exp_wr, input flush_t exp_fl);
        logic found;
        @(posedge clk);
        issue(rec, rdata);
        wait_retire(rec.pc, found);
        if (found) begin
            compare_rf_write(trace_now(), exp_wr);
            compare_flush(flush_now(), exp_fl);
        end
        if (exp_wr.we) begin
            rf_m[exp_wr.waddr] = exp_wr.wdata;
        end
    endtask

    task automatic read_back_reg(input logic [4:0] r);
        @(posedge clk);
        rf_raddr <= r;
        @(negedge clk);
        compare_word($sformatf("rf_rdata[%0d]", r), rf_rdata, rf_m[r]);
    endtask

    // rd gets the old value, csrwr writes all bits
    task automatic csr_op(input wb_pkg::inst_kind_e kind, input logic [13:0] num,
                          input logic [31:0] value, input logic [31:0] mask);
        wb_pkg::ex2ms_t rec;
        logic [4:0]     rd;
        logic [31:0]    old;
        logic [31:0]    eff;
        rd  = 5'($urandom_range(31, 1));
        old = csr_value_of(num);
        eff = (kind == wb_pkg::KIND_CSRWR) ? 32'hffff_ffff : mask;
        eff = eff & writable_bits(num);
        rec = make_rec(kind, rd, 32'h0);
        rec.csr_num    = num;
        rec.csr_wvalue = value;
        rec.csr_wmask  = mask;
        execute_and_check(rec, 32'h0, expect_write(rd, old), '0);
        if (kind != wb_pkg::KIND_CSRRD) begin
            store_csr(num, (old & ~eff) | (value & eff));
        end
    endtask

    task automatic alu_writeback();
        wb_pkg::ex2ms_t rec;
        logic [4:0]     rd;
        logic [31:0]    data;
        for (int i = 0; i < 8; i++) begin
            rd   = 5'($urandom_range(31, 1));
            data = $urandom();
            rec  = make_rec(wb_pkg::KIND_ALU, rd, data);
            execute_and_check(rec, 32'h0, expect_write(rd, data), '0);
            read_back_reg(rd);
        end
        // r0 write is dropped and not traced
        rec = make_rec(wb_pkg::KIND_ALU, 5'd0, $urandom());
        execute_and_check(rec, 32'h0, '0, '0);
        read_back_reg(5'd0);
    endtask

    task automatic load_extension();
        wb_pkg::load_op_e ops [5];
        wb_pkg::ex2ms_t   rec;
        logic [31:0]      word;
        logic [31:0]      addr;
        logic [4:0]       rd;
        ops = '{wb_pkg::LD_B, wb_pkg::LD_BU, wb_pkg::LD_H, wb_pkg::LD_HU, wb_pkg::LD_W};
        foreach (ops[k]) begin
            for (int off = 0; off < 4; off++) begin
                word = $urandom();
                addr = $urandom();
                addr[1:0] = 2'(off);
                rd = 5'($urandom_range(31, 1));
                rec = make_rec(wb_pkg::KIND_LOAD, rd, addr);
                rec.load_op = ops[k];
                execute_and_check(rec, word, expect_write(rd, extend_load(ops[k], 2'(off), word)),
                                  '0);
            end
        end
    endtask

    task automatic csr_access();
        for (int i = 0; i < 4; i++) begin
            csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_SAVE0 + 14'(i), $urandom(), 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            csr_op(wb_pkg::KIND_CSRXCHG, wb_pkg::CSR_SAVE0 + 14'(i), $urandom(), $urandom());
            csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_SAVE0 + 14'(i), 32'h0, 32'h0);
        end
        // estat ignores software writes
        csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_ESTAT, $urandom(), 32'h0);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_ESTAT, 32'h0, 32'h0);
        // low six entry bits stay zero
        csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_EENTRY, EENTRY_RESET | 32'h3f, 32'h0);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_EENTRY, 32'h0, 32'h0);
    endtask

    task automatic syscall_entry();
        wb_pkg::ex2ms_t rec;
        flush_t         fl;
        // plv 3 with interrupts on, saved into prmd
        csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_CRMD, 32'h7, 32'h0);
        rec = make_rec(wb_pkg::KIND_SYSCALL, 5'($urandom_range(31, 1)), $urandom());
        fl.flush = 1'b1;
        fl.pc    = eentry_m;
        execute_and_check(rec, 32'h0, '0, fl);
        @(negedge clk);
        compare_flush(flush_now(), '0);
        enter_exception(rec.pc);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_ERA, 32'h0, 32'h0);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_ESTAT, 32'h0, 32'h0);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_PRMD, 32'h0, 32'h0);
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_CRMD, 32'h0, 32'h0);
    endtask

    task automatic flush_squash();
        wb_pkg::ex2ms_t sys;
        wb_pkg::ex2ms_t young;
        wb_pkg::ex2ms_t later;
        flush_t         fl;
        logic           found;
        logic [4:0]     rd;
        logic [31:0]    data;
        rd    = 5'($urandom_range(31, 1));
        data  = $urandom();
        sys   = make_rec(wb_pkg::KIND_SYSCALL, 5'd0, 32'h0);
        young = make_rec(wb_pkg::KIND_ALU, rd, data);
        fl.flush = 1'b1;
        fl.pc    = eentry_m;
        // back to back, young sits in the memory stage during the flush
        @(posedge clk);
        issue(sys, 32'h0);
        issue(young, 32'h0);
        wait_retire(sys.pc, found);
        if (found) begin
            compare_flush(flush_now(), fl);
        end
        enter_exception(sys.pc);
        // young payload may sit in the stage, but never with a write enable
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (debug_wb_rf_we !== 4'b0) begin
                squash_count++;
                $display("Squashed instruction at pc %h still reached writeback", young.pc);
            end
        end
        later = make_rec(wb_pkg::KIND_ALU, rd, data);
        execute_and_check(later, 32'h0, expect_write(rd, data), '0);
        read_back_reg(rd);
    endtask

    task automatic exception_return();
        wb_pkg::ex2ms_t rec;
        flush_t         fl;
        logic [31:0]    target;
        // return to plv 1 with interrupts on
        csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_PRMD, 32'h5, 32'h0);
        target = $urandom() & 32'hffff_fffc;
        csr_op(wb_pkg::KIND_CSRWR, wb_pkg::CSR_ERA, target, 32'h0);
        rec = make_rec(wb_pkg::KIND_ERTN, 5'($urandom_range(31, 1)), 32'h0);
        fl.flush = 1'b1;
        fl.pc    = era_m;
        execute_and_check(rec, 32'h0, '0, fl);
        @(negedge clk);
        compare_flush(flush_now(), '0);
        crmd_m = prmd_m & 32'h7;
        csr_op(wb_pkg::KIND_CSRRD, wb_pkg::CSR_CRMD, 32'h0, 32'h0);
    endtask

    initial begin
        void'($urandom(32'hc98fcef3));
        resetn         = 1'b0;
        ex2ms_valid    = 1'b0;
        ex2ms          = '0;
        load_rdata     = 32'h0;
        rf_raddr       = 5'd0;
        mismatch_count = 0;
        timeout_count  = 0;
        squash_count   = 0;
        pc_next        = 32'h1c00_0000;
        crmd_m         = 32'h0;
        prmd_m         = 32'h0;
        estat_m        = 32'h0;
        era_m          = 32'h0;
        eentry_m       = EENTRY_RESET;
        rf_m[0]        = 32'h0;
        for (int i = 0; i < 4; i++) begin
            save_m[i] = 32'h0;
        end

        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compare_word("ms_allowin", {31'b0, ms_allowin}, 32'h1);
        compare_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        compare_flush(flush_now(), '0);

        alu_writeback();
        load_extension();
        csr_access();
        syscall_entry();
        flush_squash();
        exception_return();

        $display("Errors: %0d value mismatches, %0d timeouts, %0d squash failures",
                 mismatch_count, timeout_count, squash_count);
        if (mismatch_count == 0 && timeout_count == 0 && squash_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/wb_pkg.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/csr_file.sv
logic/reg_file.sv
logic/wb_core_top.sv
verif/tb_clock.sv
verif/wb_asserts.sv
verif/wb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the writeback subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module wb_tb -f filelist.f -o wb_sim

# a stopped simulation still leaves its log for the search below
./obj_dir/wb_sim 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi
